//--- hw/fpu_cfg.svh
/*
  Build-time sizing of the FP coprocessor. FPU_STAGES is only valid from 1 to 4.
  Register addresses are 5 bits wide, so FPU_NUM_REGS must stay at 32.
*/

`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Floating-point register count
`define FPU_NUM_REGS 32

// Execute depth in cycles, issue to result
`define FPU_STAGES 2

// Instruction id width on the issue and result side
`define FPU_ID_W 4

`endif

//--- hw/fpu_pkg.sv
/*
  Shared types of the FP coprocessor. Single precision only, with no rounding
  modes and no exception flags.
*/
`default_nettype none

`include "fpu_cfg.svh"

package fpu_pkg;

  // ----------------------------------------------------------------------
  // Micro-ops
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    mv_wx,   // fmv.w.x, integer bits into an FP register
    mv_xw,   // fmv.x.w, FP bits out to the core
    sgnj,
    sgnjn,
    sgnjx,
    min,
    max,
    feq,     // Compares answer on the integer side
    flt,
    fle,
    load,    // flw
    store    // fsw
  } fpu_op_e;

  // Decoded instruction as it leaves the predecoder
  typedef struct packed {
    fpu_op_e               op;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [11:0]           imm;   // Already reassembled for fsw
    logic [`FPU_ID_W-1:0]  id;
    logic                  to_x;  // Result goes to an integer register
  } fpu_uop_t;

  // Canonical quiet NaN for min/max of two NaNs
  localparam logic [31:0] FPU_CANON_NAN = 32'h7fc0_0000;

endpackage

`default_nettype wire

//--- hw/fpu_issue_if.sv
/*
  Predecoder to execute link. One valid pulse per accepted instruction with no
  ready, since the predecoder only accepts what execute can take.
*/
`timescale 1ns/1ps
`default_nettype none

interface fpu_issue_if import fpu_pkg::*; ();

  logic        valid;    // One cycle per accepted instruction
  fpu_uop_t    uop;
  logic [31:0] xreg;     // Integer rs1 operand from the core
  logic [4:0]  rd_a;     // Register file read addresses
  logic [4:0]  rd_b;
  logic [31:0] rdata_a;  // Driven by the register file
  logic [31:0] rdata_b;

  // Decoder side
  modport predecoder (
    output valid,
    output uop,
    output xreg,
    output rd_a,
    output rd_b
  );

  // Execute side, operands arrive in the issue cycle
  modport exec (
    input valid,
    input uop,
    input xreg,
    input rdata_a,
    input rdata_b
  );

endinterface

`default_nettype wire

//--- hw/fpu_predecoder.sv
/*
  Issue-side decode and hazard scoreboard. Only RV32F moves, sign injection,
  min/max, compares, flw and fsw are accepted, and a pending load blocks issue.
*/
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_predecoder import fpu_pkg::*; (
  input  logic                 ck,
  input  logic                 rst,
  input  logic                 issue_valid,
  input  logic [31:0]          issue_instr,
  input  logic [`FPU_ID_W-1:0] issue_id,
  input  logic [31:0]          xreg_rs1,
  output logic                 issue_ready,
  output logic                 issue_accept,
  input  logic                 retire_valid,
  input  logic [4:0]           retire_rd,
  input  logic                 retire_fp,
  input  logic                 load_done,
  fpu_issue_if.predecoder      iss
);

  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [2:0]  f3;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;

  fpu_op_e     op_c;
  logic        known;      // Supported encoding
  logic        use_a;      // Reads fs1
  logic        use_b;      // Reads fs2
  logic        wr_fd;      // Writes fd
  logic        to_x;
  logic [11:0] imm;
  logic        hazard;
  logic        take;

  logic [`FPU_NUM_REGS-1:0] pending;  // FP destinations still in flight
  logic        ld_busy;

  assign opc = issue_instr[6:0];
  assign f7  = issue_instr[31:25];
  assign f3  = issue_instr[14:12];
  assign rd  = issue_instr[11:7];
  assign rs1 = issue_instr[19:15];
  assign rs2 = issue_instr[24:20];

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  always_comb begin
    known = 1'b0;
    op_c  = mv_wx;
    use_a = 1'b0;
    use_b = 1'b0;
    wr_fd = 1'b0;
    to_x  = 1'b0;
    imm   = issue_instr[31:20];
    case (opc)
      7'b0000111: if (f3 == 3'b010) begin  // flw
        known = 1'b1; op_c = load; wr_fd = 1'b1;
      end
      7'b0100111: if (f3 == 3'b010) begin  // fsw, data from fs2
        known = 1'b1; op_c = store; use_b = 1'b1;
        imm = {issue_instr[31:25], issue_instr[11:7]};
      end
      7'b1010011: begin                    // OP-FP, fmt S only
        case (f7)
          7'b0010000: if (f3 <= 3'b010) begin
            known = 1'b1; use_a = 1'b1; use_b = 1'b1; wr_fd = 1'b1;
            op_c = (f3 == 3'b000) ? sgnj : (f3 == 3'b001) ? sgnjn : sgnjx;
          end
          7'b0010100: if (f3 <= 3'b001) begin
            known = 1'b1; use_a = 1'b1; use_b = 1'b1; wr_fd = 1'b1;
            op_c = (f3 == 3'b000) ? min : max;
          end
          7'b1010000: if (f3 <= 3'b010) begin
            known = 1'b1; use_a = 1'b1; use_b = 1'b1; to_x = 1'b1;
            op_c = (f3 == 3'b010) ? feq : (f3 == 3'b001) ? flt : fle;
          end
          7'b1110000: if (f3 == 3'b000 && rs2 == 5'd0) begin
            known = 1'b1; op_c = mv_xw; use_a = 1'b1; to_x = 1'b1;
          end
          7'b1111000: if (f3 == 3'b000 && rs2 == 5'd0) begin
            known = 1'b1; op_c = mv_wx; wr_fd = 1'b1;
          end
          default: known = 1'b0;
        endcase
      end
      default: known = 1'b0;
    endcase
  end

  // No same-cycle retire credit, the write lands on that edge
  assign hazard = (use_a && pending[rs1]) || (use_b && pending[rs2]) ||
                  (wr_fd && pending[rd]);
  assign issue_ready  = !ld_busy && !hazard;
  assign issue_accept = issue_valid && issue_ready && known;
  assign take         = issue_accept;

  // Micro-op toward execute
  assign iss.valid = take;
  assign iss.uop   = '{op: op_c, rd: rd, rs1: rs1, rs2: rs2, imm: imm,
                       id: issue_id, to_x: to_x};
  assign iss.xreg  = xreg_rs1;
  assign iss.rd_a  = rs1;
  assign iss.rd_b  = rs2;

  // ----------------------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------------------
  always_ff @(posedge ck) begin
    if (rst) begin
      pending <= '0;
      ld_busy <= 1'b0;
    end else begin
      if (retire_valid && retire_fp) pending[retire_rd] <= 1'b0;
      if (take && wr_fd) pending[rd] <= 1'b1;  // Never the retiring one
      if (load_done) ld_busy <= 1'b0;
      if (take && op_c == load) ld_busy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/fpu_regfile.sv
/*
  FP register file, two combinational reads and one write. No read bypass,
  the scoreboard keeps readers off registers that are still being written.
*/
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_regfile (
  input  logic        ck,
  input  logic        rst,
  input  logic [4:0]  rd_a,
  input  logic [4:0]  rd_b,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b,
  input  logic        wr_en,
  input  logic [4:0]  wr_addr,
  input  logic [31:0] wr_data
);

  logic [31:0] regs [`FPU_NUM_REGS];

  // Reset leaves every register at +0.0
  always_ff @(posedge ck) begin
    if (rst) begin
      for (int i = 0; i < `FPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;  // From execute, last stage or load
    end
  end

  // Issue-cycle operand reads
  assign rdata_a = regs[rd_a];
  assign rdata_b = regs[rd_b];

endmodule

`default_nettype wire

//--- hw/fpu_exec.sv
/*
  Fixed-depth execute pipe, results leave in issue order without back-pressure.
  Memory must answer a load at least one cycle after its mem_valid.
*/
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_exec import fpu_pkg::*; (
  input  logic                 ck,
  input  logic                 rst,
  fpu_issue_if.exec            iss,
  output logic                 wr_en,
  output logic [4:0]           wr_addr,
  output logic [31:0]          wr_data,
  output logic                 result_valid,
  output logic [`FPU_ID_W-1:0] result_id,
  output logic [31:0]          result_data,
  output logic                 mem_valid,
  output logic                 mem_we,
  output logic [31:0]          mem_addr,
  output logic [31:0]          mem_wdata,
  input  logic                 mem_result_valid,
  input  logic [31:0]          mem_rdata,
  output logic                 retire_valid,
  output logic [4:0]           retire_rd,
  output logic                 retire_fp,
  output logic                 load_done
);

  localparam int last_st = `FPU_STAGES - 1;

  logic [31:0] a, b, res, ea;
  logic        a_nan, b_nan, both_zero, a_lt, eq;

  logic [`FPU_STAGES-1:0] st_valid;
  fpu_uop_t    st_uop  [`FPU_STAGES];
  logic [31:0] st_data [`FPU_STAGES];  // Result, or store data
  logic [31:0] st_addr [`FPU_STAGES];

  logic        wait_busy;  // Load out at memory
  fpu_uop_t    wait_uop;
  logic        ld_valid;
  logic [31:0] ld_data;
  fpu_op_e     last_op;
  logic        last_ld, pipe_res, pipe_fp;

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != '0);
  endfunction

  // Total order on non-NaN values, -0 below +0
  function automatic logic tot_lt(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) return x[31];
    return x[31] ? (x[30:0] > y[30:0]) : (x[30:0] < y[30:0]);
  endfunction

  // ----------------------------------------------------------------------
  // First stage compute
  // ----------------------------------------------------------------------
  assign a         = iss.rdata_a;
  assign b         = iss.rdata_b;
  assign a_nan     = is_nan(a);
  assign b_nan     = is_nan(b);
  assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
  assign a_lt      = tot_lt(a, b);
  assign eq        = (a == b) || both_zero;  // IEEE equality, +0 == -0
  assign ea        = iss.xreg + {{20{iss.uop.imm[11]}}, iss.uop.imm};

  always_comb begin
    res = '0;
    case (iss.uop.op)
      mv_wx: res = iss.xreg;
      mv_xw: res = a;
      sgnj:  res = {b[31], a[30:0]};
      sgnjn: res = {~b[31], a[30:0]};
      sgnjx: res = {a[31] ^ b[31], a[30:0]};
      min, max: begin
        if (a_nan && b_nan) res = FPU_CANON_NAN;
        else if (a_nan)     res = b;
        else if (b_nan)     res = a;
        else                res = (a_lt ^ (iss.uop.op == max)) ? a : b;
      end
      feq:   res = {31'd0, !a_nan && !b_nan && eq};
      flt:   res = {31'd0, !a_nan && !b_nan && !both_zero && a_lt};
      fle:   res = {31'd0, !a_nan && !b_nan && (eq || a_lt)};
      store: res = b;  // Word to memory
      default: res = '0;  // load fills in later
    endcase
  end

  // ----------------------------------------------------------------------
  // Stage shift
  // ----------------------------------------------------------------------
  always_ff @(posedge ck) begin
    if (rst) begin
      st_valid <= '0;
    end else begin
      st_valid[0] <= iss.valid;
      for (int i = 1; i < `FPU_STAGES; i++) st_valid[i] <= st_valid[i-1];
    end
  end

  always_ff @(posedge ck) begin
    st_uop[0]  <= iss.uop;
    st_data[0] <= res;
    st_addr[0] <= ea;
    for (int i = 1; i < `FPU_STAGES; i++) begin
      st_uop[i]  <= st_uop[i-1];
      st_data[i] <= st_data[i-1];
      st_addr[i] <= st_addr[i-1];
    end
  end

  assign last_op  = st_uop[last_st].op;
  assign last_ld  = st_valid[last_st] && last_op == load;
  assign pipe_res = st_valid[last_st] && last_op != load;  // Loads answer later
  assign pipe_fp  = !st_uop[last_st].to_x && last_op != store;

  // Load park, at most one by the scoreboard
  always_ff @(posedge ck) begin
    if (rst) begin
      wait_busy <= 1'b0;
      ld_valid  <= 1'b0;
    end else begin
      ld_valid <= wait_busy && mem_result_valid;
      if (wait_busy && mem_result_valid) wait_busy <= 1'b0;
      else if (last_ld) wait_busy <= 1'b1;
    end
  end

  always_ff @(posedge ck) begin
    if (last_ld) wait_uop <= st_uop[last_st];
    if (mem_result_valid) ld_data <= mem_rdata;
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign mem_valid = st_valid[last_st] && (last_op == load || last_op == store);
  assign mem_we    = last_op == store;
  assign mem_addr  = st_addr[last_st];
  assign mem_wdata = st_data[last_st];

  assign result_valid = pipe_res || ld_valid;  // Never both, issue waits on load
  assign result_id    = ld_valid ? wait_uop.id : st_uop[last_st].id;
  assign result_data  = ld_valid ? ld_data : st_data[last_st];

  assign wr_en   = ld_valid || (pipe_res && pipe_fp);
  assign wr_addr = ld_valid ? wait_uop.rd : st_uop[last_st].rd;
  assign wr_data = result_data;

  assign retire_valid = result_valid;
  assign retire_rd    = wr_addr;
  assign retire_fp    = wr_en;
  assign load_done    = ld_valid;

endmodule

`default_nettype wire

//--- hw/fpu_top.sv
/*
  RV32F coprocessor subset with plain core-side strobes. Results must be taken
  when result_valid is high, there is no result back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_top (
  input  logic                 ck,
  input  logic                 rst,
  // Issue
  input  logic                 issue_valid,
  output logic                 issue_ready,
  input  logic [31:0]          issue_instr,
  input  logic [`FPU_ID_W-1:0] issue_id,
  output logic                 issue_accept,
  input  logic [31:0]          xreg_rs1,
  // Result
  output logic                 result_valid,
  output logic [`FPU_ID_W-1:0] result_id,
  output logic [31:0]          result_data,
  // Memory request and answer
  output logic                 mem_valid,
  output logic                 mem_we,
  output logic [31:0]          mem_addr,
  output logic [31:0]          mem_wdata,
  input  logic                 mem_result_valid,
  input  logic [31:0]          mem_rdata
);

  // ----------------------------------------------------------------------
  // Internal links
  // ----------------------------------------------------------------------
  fpu_issue_if iss ();

  logic        wr_en;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;
  logic        retire_valid;  // Scoreboard release
  logic [4:0]  retire_rd;
  logic        retire_fp;
  logic        load_done;

  fpu_predecoder u_predecoder (
    .ck           (ck),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_instr  (issue_instr),
    .issue_id     (issue_id),
    .xreg_rs1     (xreg_rs1),
    .issue_ready  (issue_ready),
    .issue_accept (issue_accept),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_fp    (retire_fp),
    .load_done    (load_done),
    .iss          (iss.predecoder)
  );

  // Read side hangs off the issue interface
  fpu_regfile u_regfile (
    .ck      (ck),
    .rst     (rst),
    .rd_a    (iss.rd_a),
    .rd_b    (iss.rd_b),
    .rdata_a (iss.rdata_a),
    .rdata_b (iss.rdata_b),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  fpu_exec u_exec (
    .ck               (ck),
    .rst              (rst),
    .iss              (iss.exec),
    .wr_en            (wr_en),
    .wr_addr          (wr_addr),
    .wr_data          (wr_data),
    .result_valid     (result_valid),
    .result_id        (result_id),
    .result_data      (result_data),
    .mem_valid        (mem_valid),
    .mem_we           (mem_we),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .mem_result_valid (mem_result_valid),
    .mem_rdata        (mem_rdata),
    .retire_valid     (retire_valid),
    .retire_rd        (retire_rd),
    .retire_fp        (retire_fp),
    .load_done        (load_done)
  );

endmodule

`default_nettype wire

//--- bench/fpu_asserts.sv
/*
  Protocol checks bound into fpu_top. Latency check treats every accepted
  OP-FP encoding as a non-memory instruction.
*/
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_asserts (
  input logic        ck,
  input logic        rst,
  input logic        issue_valid,
  input logic        issue_accept,
  input logic [31:0] issue_instr,
  input logic        result_valid,
  input logic        mem_valid,
  input logic        mem_we,
  input logic        mem_result_valid
);

  logic ld_out;  // Load sent, answer not yet seen

  always_ff @(posedge ck) begin
    if (rst) begin
      ld_out <= 1'b0;
    end else if (mem_result_valid) begin
      ld_out <= 1'b0;
    end else if (mem_valid && !mem_we) begin
      ld_out <= 1'b1;
    end
  end

  accept_needs_valid: assert property (@(posedge ck) disable iff (rst)
    issue_accept |-> issue_valid)
    else $error("issue_accept high without issue_valid");

  // Moves, sign injection, min/max and compares all share the OP-FP opcode
  fixed_latency: assert property (@(posedge ck) disable iff (rst)
    issue_accept && issue_instr[6:0] == 7'b1010011 |-> ##(`FPU_STAGES) result_valid)
    else $error("result_valid missing at the fixed pipeline depth");

  one_load_at_memory: assert property (@(posedge ck) disable iff (rst)
    ld_out |-> !mem_valid)
    else $error("memory request while a load is outstanding");

  quiet_in_reset: assert property (@(posedge ck)
    rst && $past(rst) |-> !result_valid && !mem_valid && !issue_accept)
    else $error("control output high during reset");

endmodule

bind fpu_top fpu_asserts u_asserts (
  .ck               (ck),
  .rst              (rst),
  .issue_valid      (issue_valid),
  .issue_accept     (issue_accept),
  .issue_instr      (issue_instr),
  .result_valid     (result_valid),
  .mem_valid        (mem_valid),
  .mem_we           (mem_we),
  .mem_result_valid (mem_result_valid)
);

`default_nettype wire

//--- bench/fpu_tb.sv
/*
  Testbench for the FP coprocessor, run from the project root for the cases file.
  Memory answers each load 1 to 4 cycles after its request.
*/
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_tb;

  localparam int num_cases   = 31;
  localparam int ready_limit = 50;   // Cycles per issue_ready wait
  localparam int drain_limit = 100;  // Cycles for the last results

  logic                 ck;
  logic                 rst;
  logic                 issue_valid;
  logic                 issue_ready;
  logic [31:0]          issue_instr;
  logic [`FPU_ID_W-1:0] issue_id;
  logic                 issue_accept;
  logic [31:0]          xreg_rs1;
  logic                 result_valid;
  logic [`FPU_ID_W-1:0] result_id;
  logic [31:0]          result_data;
  logic                 mem_valid;
  logic                 mem_we;
  logic [31:0]          mem_addr;
  logic [31:0]          mem_wdata;
  logic                 mem_result_valid;
  logic [31:0]          mem_rdata;

  logic [31:0]          case_words [4*num_cases];  // Four words per case
  logic [`FPU_ID_W-1:0] exp_id_q [$];              // Accepted, in issue order
  logic [31:0]          exp_data_q [$];
  logic [31:0]          exp_addr_q [$];            // Memory requests in order
  logic                 exp_we_q [$];
  logic [31:0]          exp_wdata_q [$];
  logic [31:0]          mem [logic [31:0]];

  fpu_top u_fpu_top (
    .ck               (ck),
    .rst              (rst),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .issue_instr      (issue_instr),
    .issue_id         (issue_id),
    .issue_accept     (issue_accept),
    .xreg_rs1         (xreg_rs1),
    .result_valid     (result_valid),
    .result_id        (result_id),
    .result_data      (result_data),
    .mem_valid        (mem_valid),
    .mem_we           (mem_we),
    .mem_addr         (mem_addr),
    .mem_wdata        (mem_wdata),
    .mem_result_valid (mem_result_valid),
    .mem_rdata        (mem_rdata)
  );

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // RISC-V I and S immediates, sign extended
  function automatic logic [31:0] mem_offset(input logic [31:0] instr);
    logic [11:0] imm;
    if (instr[6:0] == 7'b0100111) imm = {instr[31:25], instr[11:7]};
    else imm = instr[31:20];
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] a);
    if (mem.exists(a)) return mem[a];
    return a ^ 32'h5a5a_c3c3;  // Untouched words follow the address
  endfunction

  initial begin
    ck = 1'b0;
    forever #50 ck = ~ck;
  end

  // ----------------------------------------------------------------------
  // Issue side
  // ----------------------------------------------------------------------
  initial begin : issue_proc
    int                   wait_cnt;
    logic [31:0]          instr;
    logic                 accept_exp;
    logic [`FPU_ID_W-1:0] next_id;
    rst         = 1'b1;
    issue_valid = 1'b0;
    issue_instr = '0;
    issue_id    = '0;
    xreg_rs1    = '0;
    next_id     = '0;
    $readmemh("bench/fpu_cases.txt", case_words);
    repeat (4) @(posedge ck);
    #1 rst = 1'b0;
    @(negedge ck);
    // Idle state once reset is released
    assert (issue_ready === 1'b1 && result_valid === 1'b0 && mem_valid === 1'b0) else
      abort_run($sformatf("error %0t: after reset issue_ready %b result_valid %b mem_valid %b",
                          $time, issue_ready, result_valid, mem_valid));
    @(posedge ck);
    #1;
    for (int n = 0; n < num_cases; n++) begin
      instr       = case_words[4*n];
      accept_exp  = case_words[4*n+2][0];
      issue_valid = 1'b1;
      issue_instr = instr;
      issue_id    = next_id;
      xreg_rs1    = case_words[4*n+1];
      wait_cnt    = 0;
      @(negedge ck);
      while (!issue_ready && wait_cnt < ready_limit) begin  // Scoreboard stall
        wait_cnt++;
        @(negedge ck);
      end
      if (!issue_ready) abort_run($sformatf("issue_ready never rose for case %0d", n));
      assert (issue_accept === accept_exp) else
        abort_run($sformatf("error %0t: case %0d issue_accept %b, expected %b",
                            $time, n, issue_accept, accept_exp));
      if (accept_exp) begin
        exp_id_q.push_back(next_id);
        exp_data_q.push_back(case_words[4*n+3]);
        if (instr[6:0] == 7'b0100111 || instr[6:0] == 7'b0000111) begin
          exp_addr_q.push_back(xreg_rs1 + mem_offset(instr));
          exp_we_q.push_back(instr[6:0] == 7'b0100111);
          exp_wdata_q.push_back(case_words[4*n+3]);
        end
      end
      next_id = next_id + 4'd1;  // Rejected ids are skipped for good
      @(posedge ck);
      #1;
    end
    issue_valid = 1'b0;
    wait_cnt = 0;
    while ((exp_id_q.size() != 0 || exp_addr_q.size() != 0) && wait_cnt < drain_limit) begin
      wait_cnt++;
      @(negedge ck);
    end
    repeat (2 * `FPU_STAGES) @(negedge ck);  // Window for stray results
    if (exp_id_q.size() == 0 && exp_addr_q.size() == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("results or memory requests still missing at the end");
    end
  end

  // ----------------------------------------------------------------------
  // Result monitor, sampled mid-cycle
  // ----------------------------------------------------------------------
  always @(negedge ck) begin
    if (!rst && result_valid) begin
      assert (exp_id_q.size() != 0) else
        abort_run($sformatf("error %0t: result id %0d with nothing outstanding",
                            $time, result_id));
      assert (result_id === exp_id_q[0]) else
        abort_run($sformatf("error %0t: result id %0d, expected %0d",
                            $time, result_id, exp_id_q[0]));
      assert (result_data === exp_data_q[0]) else
        abort_run($sformatf("error %0t: id %0d result_data %h, expected %h",
                            $time, result_id, result_data, exp_data_q[0]));
      void'(exp_id_q.pop_front());
      void'(exp_data_q.pop_front());
    end
  end

  // ----------------------------------------------------------------------
  // Memory model
  // ----------------------------------------------------------------------
  initial begin : memory_model
    logic [31:0] lfsr;
    logic [31:0] addr;
    logic [1:0]  gap_bits;
    int          gap;
    lfsr             = 32'h868832cb;
    mem_result_valid = 1'b0;
    mem_rdata        = '0;
    forever begin
      @(negedge ck);
      if (!rst && mem_valid) begin
        assert (exp_addr_q.size() != 0) else
          abort_run($sformatf("error %0t: unexpected memory request", $time));
        assert (mem_we === exp_we_q[0]) else
          abort_run($sformatf("error %0t: mem_we %b, expected %b", $time, mem_we, exp_we_q[0]));
        assert (mem_addr === exp_addr_q[0]) else
          abort_run($sformatf("error %0t: mem_addr %h, expected %h",
                              $time, mem_addr, exp_addr_q[0]));
        if (mem_we) begin
          assert (mem_wdata === exp_wdata_q[0]) else
            abort_run($sformatf("error %0t: mem_wdata %h, expected %h",
                                $time, mem_wdata, exp_wdata_q[0]));
          mem[mem_addr] = mem_wdata;
        end
        void'(exp_addr_q.pop_front());
        void'(exp_we_q.pop_front());
        void'(exp_wdata_q.pop_front());
        if (!mem_we) begin
          addr = mem_addr;
          for (int k = 0; k < 2; k++) begin  // One step per gap bit
            lfsr     = lfsr_step(lfsr);
            gap_bits = {gap_bits[0], lfsr[0]};
          end
          gap = int'(gap_bits) + 1;
          repeat (gap) @(posedge ck);
          #1;
          mem_result_valid = 1'b1;
          mem_rdata        = read_word(addr);
          @(posedge ck);
          #1;
          mem_result_valid = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_issue_if.sv
hw/fpu_predecoder.sv
hw/fpu_regfile.sv
hw/fpu_exec.sv
hw/fpu_top.sv
bench/fpu_asserts.sv
bench/fpu_tb.sv

//--- Makefile
# Verilator build and run of the FP coprocessor testbench.
# Override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= fpu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SOURCES   := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation reads bench/fpu_cases.txt, so it runs from the project root
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/fpu_cases.txt
// Columns, all hex: instruction, integer rs1 operand, expected accept (1 or 0),
// expected result_data (for fsw also the word written to memory)
F00500D3 3f800000 1 3f800000 // fmv.w.x f1 = 1.0
E0008553 00000000 1 3f800000 // fmv.x.w f1, waits on f1
F0050153 c0000000 1 c0000000 // f2 = -2.0
F00501D3 7fa00000 1 7fa00000 // f3 = NaN
F0050253 80000000 1 80000000 // f4 = -0
F00502D3 00000000 1 00000000 // f5 = +0
F0050353 40490fdb 1 40490fdb // f6 = pi
202083D3 00000000 1 bf800000 // fsgnj f7, f1, f2
20209453 00000000 1 3f800000 // fsgnjn f8, f1, f2
202124D3 00000000 1 40000000 // fsgnjx f9, f2, f2
E0038553 00000000 1 bf800000 // fmv.x.w f7
28208553 00000000 1 c0000000 // fmin f10, f1, f2
283095D3 00000000 1 3f800000 // fmax f11, f1, NaN
28318653 00000000 1 7fc00000 // fmin f12, NaN, NaN
284286D3 00000000 1 80000000 // fmin f13, +0, -0
28521753 00000000 1 00000000 // fmax f14, -0, +0
A0522553 00000000 1 00000001 // feq -0, +0
A0111553 00000000 1 00000001 // flt -2.0, 1.0
A0521553 00000000 1 00000000 // flt -0, +0
A0308553 00000000 1 00000000 // fle 1.0, NaN
A0108553 00000000 1 00000001 // fle 1.0, 1.0
A031A553 00000000 1 00000000 // feq NaN, NaN
002087D3 00000000 0 00000000 // fadd.s, rejected
003100B3 00000000 0 00000000 // integer add, rejected
00652427 00001000 1 40490fdb // fsw f6, 8(a0)
00852787 00001000 1 40490fdb // flw f15, 8(a0)
E0078553 00000000 1 40490fdb // fmv.x.w f15, waits on load
FE252E27 00002000 1 c0000000 // fsw f2, -4(a0)
FFC52807 00002000 1 c0000000 // flw f16, -4(a0)
21081853 00000000 1 40000000 // fsgnjn f16, f16, f16
E0080553 00000000 1 40000000 // fmv.x.w f16
